//--- compile.f
logic/isaPkg.sv
logic/shiftPkg.sv
logic/shiftDecode.sv
logic/barrelShifter.sv
logic/shiftUnit.sv
tests/shiftUnitTb.sv

//--- logic/barrelShifter.sv
// Logarithmic barrel shifter for left logical, right logical and right arithmetic shifts
// Left shifts reuse the right-shift chain by reversing the bit order on the way in and out
module barrelShifter
    import shiftPkg::*;
#(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0]         value,
    input  logic [$clog2(dataWidth)-1:0] amount,
    input  shiftOp_t                     op,
    output logic [dataWidth-1:0]         result
);

    // One stage per amount bit
    localparam int stageCount = $clog2(dataWidth);

    // Mirror a word so bit 0 becomes the MSB
    function automatic logic [dataWidth-1:0] reverseBits(input logic [dataWidth-1:0] vec);
        logic [dataWidth-1:0] flipped;
        for (int i = 0; i < dataWidth; i++) begin
            flipped[i] = vec[dataWidth-1-i];
        end
        return flipped;
    endfunction

    // ------------------------------
    // Shift chain
    // ------------------------------

    always_comb begin : shiftChain
        logic                 isLeft;
        logic                 fillBit;
        logic [dataWidth-1:0] work;
        logic [dataWidth-1:0] fillMask;

        isLeft   = (op == shiftLeftLogical);
        fillMask = '0;

        // Sign fill only for arithmetic shifts, zeros otherwise
        fillBit = (op == shiftRightArith) ? value[dataWidth-1] : 1'b0;

        work = isLeft ? reverseBits(value) : value;

        // Stage i moves right by 2**i when amount bit i is set
        for (int i = 0; i < stageCount; i++) begin
            if (amount[i]) begin
                fillMask = ~({dataWidth{1'b1}} >> (1 << i));
                work     = (work >> (1 << i)) | (fillBit ? fillMask : '0);
            end
        end

        // undo the mirror for left shifts
        result = isLeft ? reverseBits(work) : work;

        // No shift leaves the operand alone in every mode
        if (amount == '0) begin
            assert (result == value)
            else $error("barrelShifter: zero shift changed %h into %h", value, result);
        end
    end

endmodule : barrelShifter

//--- logic/isaPkg.sv
// MIPS I instruction encoding for the shift unit and its testbench
// Word and register index types, the R-type field view and the SPECIAL function codes
package isaPkg;

    // ------------------------------
    // Data and register types
    // ------------------------------

    // Architectural data word
    localparam int wordWidth = 32;

    // 32 general registers
    localparam int regIndexWidth = 5;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [regIndexWidth-1:0] regIndex_t;

    // Primary opcode and SPECIAL function fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // ------------------------------
    // Instruction formats
    // ------------------------------

    // R-type layout, most significant field first
    // bits 31:26 opcode, 25:21 rs, 20:16 rt, 15:11 rd, 10:6 shamt, 5:0 funct
    typedef struct packed {
        opcode_t    opcode;
        regIndex_t  rs;
        regIndex_t  rt;
        regIndex_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rType_t;

    // Same 32 bits seen as decoded fields or as the raw fetched word
    typedef union packed {
        rType_t fields;
        word_t  raw;
    } instrWord_t;

    // ------------------------------
    // Encodings
    // ------------------------------

    // All shifts live under the SPECIAL opcode
    localparam opcode_t opSpecial = 6'h00;

    // Shift amount taken from shamt, rs must be zero
    localparam funct_t functSll = 6'h00;
    localparam funct_t functSrl = 6'h02;
    localparam funct_t functSra = 6'h03;

    // Shift amount taken from GPR[rs], shamt must be zero
    localparam funct_t functSllv = 6'h04;
    localparam funct_t functSrlv = 6'h06;
    localparam funct_t functSrav = 6'h07;

endpackage : isaPkg

//--- logic/shiftDecode.sv
// Combinational decode of one MIPS shift instruction
// Gives the shift kind, the amount, the destination rd and whether the encoding is legal
module shiftDecode
    import isaPkg::*;
    import shiftPkg::*;
(
    input  instrWord_t   instruction,
    input  word_t        gprA,
    output logic         legal,
    output shiftOp_t     op,
    output shiftAmount_t amount,
    output regIndex_t    destIndex
);

    // ------------------------------
    // Field views
    // ------------------------------

    // Only the R-type view is meaningful for shifts
    rType_t fields;

    assign fields = instruction.fields;

    // Result always lands in rd
    assign destIndex = fields.rd;

    // ------------------------------
    // Function decode
    // ------------------------------

    always_comb begin : decodeShift
        logic isSpecial;
        logic isShift;
        logic isVariable;
        logic zeroFieldOk;

        isSpecial  = (fields.opcode == opSpecial);
        isShift    = 1'b1;
        isVariable = 1'b0;
        op         = shiftLeftLogical;

        // Pick the shifter mode and the amount source from funct
        case (fields.funct)
            functSll: begin
                op = shiftLeftLogical;
            end
            functSrl: begin
                op = shiftRightLogical;
            end
            functSra: begin
                op = shiftRightArith;
            end
            functSllv: begin
                op         = shiftLeftLogical;
                isVariable = 1'b1;
            end
            functSrlv: begin
                op         = shiftRightLogical;
                isVariable = 1'b1;
            end
            functSrav: begin
                op         = shiftRightArith;
                isVariable = 1'b1;
            end
            default: begin
                // Any other SPECIAL function belongs to another unit
                isShift = 1'b0;
            end
        endcase

        // Variable forms use only the low five bits of rs data
        if (isVariable) begin
            amount = gprA[$bits(shiftAmount_t)-1:0];
        end else begin
            amount = fields.shamt;
        end

        // The field a form does not use has to be zero
        // shamt form needs rs == 0, variable form needs shamt == 0
        if (isVariable) begin
            zeroFieldOk = (fields.shamt == '0);
        end else begin
            zeroFieldOk = (fields.rs == '0);
        end

        legal = isSpecial && isShift && zeroFieldOk;
    end

endmodule : shiftDecode

//--- logic/shiftPkg.sv
// Shift datapath types shared by the decoder, the barrel shifter and the top level
package shiftPkg;

    // ------------------------------
    // Shift control
    // ------------------------------

    // Kind of shift the barrel shifter performs
    // encoding 2'b11 is unused and never leaves a legal decode
    typedef enum logic [1:0] {
        shiftLeftLogical  = 2'b00,
        shiftRightLogical = 2'b01,
        shiftRightArith   = 2'b10
    } shiftOp_t;

    // ------------------------------
    // Shift count
    // ------------------------------

    // Enough bits to shift a 32-bit word by 0..31
    localparam int shiftAmountWidth = 5;

    typedef logic [shiftAmountWidth-1:0] shiftAmount_t;

endpackage : shiftPkg

//--- logic/shiftUnit.sv
// MIPS I shift execute unit, one instruction per cycle with no back-pressure
// Decodes the instruction, shifts rt data and registers the rd write-back one clock later
module shiftUnit
    import isaPkg::*;
    import shiftPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  instrWord_t instruction,
    input  word_t      gprA,
    input  word_t      gprB,
    output logic       gprCWrite,
    output regIndex_t  gprCIndex,
    output word_t      gprCData
);

    // ------------------------------
    // Decode and datapath
    // ------------------------------

    logic         legal;
    shiftOp_t     op;
    shiftAmount_t amount;
    regIndex_t    destIndex;
    word_t        shiftResult;

    // Issue only counts when the slot is valid and the encoding is legal
    logic writeEnable;

    shiftDecode decode_i (
        .instruction (instruction),
        .gprA        (gprA),
        .legal       (legal),
        .op          (op),
        .amount      (amount),
        .destIndex   (destIndex)
    );

    // rt data is the shifted operand
    barrelShifter #(
        .dataWidth (wordWidth)
    ) shifter_i (
        .value  (gprB),
        .amount (amount),
        .op     (op),
        .result (shiftResult)
    );

    assign writeEnable = instrValid && legal;

    // ------------------------------
    // Write-back register
    // ------------------------------

    // Index and data load on every valid issue, write strobe only when legal
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gprCWrite <= 1'b0;
            gprCIndex <= '0;
            gprCData  <= '0;
        end else begin
            gprCWrite <= writeEnable;
            if (instrValid) begin
                gprCIndex <= destIndex;
                gprCData  <= shiftResult;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Register file write enable must be clean after reset
    gprCWriteKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(gprCWrite)
    ) else $error("shiftUnit: gprCWrite is unknown");

    // A write can only start one clock after a valid issue
    writeFollowsIssue: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(gprCWrite) |-> $past(instrValid)
    ) else $error("shiftUnit: gprCWrite rose without a valid issue the cycle before");

endmodule : shiftUnit

//--- run.sh
#!/bin/sh
# Build the shift unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module shiftUnitTb -f compile.f

# Exit status of the simulation is the pass or fail result
./obj_dir/VshiftUnitTb

//--- tests/shiftPatterns.mem
// Columns: instrValid instruction gprA gprB expWrite expIndex expData
// expIndex and expData are only compared on records whose expWrite is 1
// SLL, SRL and SRA with the amount in shamt
1 00011100 00000000 00000001 1 02 00000010
1 00041FC0 00000000 00000003 1 03 80000000
1 00062800 00000000 12345678 1 05 12345678
1 00083A02 00000000 F0F0F0F0 1 07 00F0F0F0
1 000A4FC2 00000000 80000000 1 09 00000001
1 000C5903 00000000 80000000 1 0B F8000000
1 000E6C03 00000000 7FFF1234 1 0D 00007FFF
1 00107FC3 00000000 FFFFFFFE 1 0F FFFFFFFF
// SLLV, SRLV and SRAV, each pair differs only in the high bits of gprA
1 00228804 00000008 000000FF 1 11 0000FF00
1 00228804 FFFFFFE8 000000FF 1 11 0000FF00
1 00649006 00000010 ABCD0000 1 12 0000ABCD
1 00649006 12345670 ABCD0000 1 12 0000ABCD
1 00A69807 00000004 80000010 1 13 F8000001
1 00A69807 FFFFFFE4 80000010 1 13 F8000001
1 00E8A007 0000001F 40000000 1 14 00000000
// Illegal encodings, other functions, other opcodes and an idle slot
1 00211100 00000000 00000001 0 00 00000000
1 03EC5903 00000000 80000000 0 00 00000000
1 00228844 00000008 000000FF 0 00 00000000
1 00A69FC7 00000004 80000010 0 00 00000000
1 00221820 00000001 00000002 0 00 00000000
1 00011101 00000000 00000001 0 00 00000000
1 20011100 00000000 00000001 0 00 00000000
0 00011100 00000000 00000001 0 00 00000000
// Legal issues again after the idle slot
1 0001F842 00000000 FFFFFFFF 1 1F 7FFFFFFF
1 00000000 00000000 DEADBEEF 1 00 DEADBEEF

//--- tests/shiftUnitTb.sv
// Testbench for the MIPS shift unit
// Replays the pattern records, then a random back-to-back stream checked against a model
module shiftUnitTb
    import isaPkg::*;
;

    localparam int clockPeriod   = 4;
    localparam int patternCount  = 25;
    localparam int recordWords   = 7;
    localparam int randomCount   = 200;
    localparam int watchdogLimit = (patternCount + randomCount + 8 + 20) * clockPeriod;

    logic       clk;
    logic       rstN;
    logic       instrValid;
    instrWord_t instruction;
    word_t      gprA;
    word_t      gprB;
    logic       gprCWrite;
    regIndex_t  gprCIndex;
    word_t      gprCData;

    // One 32-bit word per column, seven per record
    logic [31:0] patternMem [0:patternCount*recordWords-1];

    // Generator state, fixed seed
    int unsigned lcgState = 48;

    shiftUnit shiftUnit_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instruction (instruction),
        .gprA        (gprA),
        .gprB        (gprB),
        .gprCWrite   (gprCWrite),
        .gprCIndex   (gprCIndex),
        .gprCData    (gprCData)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    // ------------------------------
    // Failure and compare tasks
    // ------------------------------

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkWrite(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail %s write expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkIndex(input string name, input regIndex_t expected,
                              input regIndex_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail %s index expected %0d actual %0d",
                                  name, expected, actual));
        end
    endtask

    task automatic checkData(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail %s data expected %h actual %h", name, expected, actual));
        end
    endtask

    // Index and data only matter when a write is expected
    task automatic checkIssue(input string name, input logic expWrite, input regIndex_t expIndex,
                              input word_t expData);
        checkWrite(name, expWrite, gprCWrite);
        if (expWrite) begin
            checkIndex(name, expIndex, gprCIndex);
            checkData(name, expData, gprCData);
        end
    endtask

    task automatic checkResetState(input string name);
        checkWrite(name, 1'b0, gprCWrite);
        checkIndex(name, '0, gprCIndex);
        checkData(name, '0, gprCData);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // shamt forms need rs zero, variable forms need shamt zero
    function automatic logic expectWrite(input instrWord_t ins);
        logic formOk;
        if (ins.fields.opcode != opSpecial) begin
            return 1'b0;
        end
        case (ins.fields.funct)
            functSll, functSrl, functSra:    formOk = (ins.fields.rs == '0);
            functSllv, functSrlv, functSrav: formOk = (ins.fields.shamt == '0);
            default:                         formOk = 1'b0;
        endcase
        return formOk;
    endfunction

    function automatic word_t expectData(input instrWord_t ins, input word_t a, input word_t b);
        logic [4:0] count;
        word_t      shifted;
        // Variable forms take the low five bits of rs data
        if (ins.fields.funct inside {functSllv, functSrlv, functSrav}) begin
            count = a[4:0];
        end else begin
            count = ins.fields.shamt;
        end
        case (ins.fields.funct)
            functSll, functSllv: shifted = b << count;
            functSrl, functSrlv: shifted = b >> count;
            functSra, functSrav: shifted = $signed(b) >>> count;
            default:             shifted = '0;
        endcase
        return shifted;
    endfunction

    // ------------------------------
    // Random stimulus
    // ------------------------------

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Upper halves only, the low LCG bits repeat too quickly
    function automatic word_t randomWord();
        int unsigned first;
        int unsigned second;
        first  = nextRandom();
        second = nextRandom();
        return {first[31:16], second[31:16]};
    endfunction

    // Mostly SPECIAL shifts with the unused field cleared
    function automatic instrWord_t randomInstr();
        instrWord_t  ins;
        int unsigned pick;
        funct_t      shiftFuncts [6];
        shiftFuncts = '{functSll, functSrl, functSra, functSllv, functSrlv, functSrav};
        ins.raw     = randomWord();
        pick        = nextRandom();
        if (pick[18:16] < 3'd6) begin
            ins.fields.funct = shiftFuncts[pick[18:16]];
        end
        if (pick[23:20] != 4'h0) begin
            ins.fields.opcode = opSpecial;
        end
        if (pick[25:24] != 2'b00) begin
            if (ins.fields.funct inside {functSllv, functSrlv, functSrav}) begin
                ins.fields.shamt = '0;
            end else begin
                ins.fields.rs = '0;
            end
        end
        return ins;
    endfunction

    // ------------------------------
    // Test phases
    // ------------------------------

    // Result of record i is checked on the falling edge that drives record i+1
    task automatic runPatterns();
        int        base;
        logic      expWrite;
        regIndex_t expIndex;
        word_t     expData;
        for (int i = 0; i < patternCount; i++) begin
            base = i * recordWords;
            @(negedge clk);
            if (i > 0) begin
                checkIssue($sformatf("pattern %0d", i - 1), expWrite, expIndex, expData);
            end
            instrValid      = patternMem[base][0];
            instruction.raw = patternMem[base + 1];
            gprA            = patternMem[base + 2];
            gprB            = patternMem[base + 3];
            expWrite        = patternMem[base + 4][0];
            expIndex        = patternMem[base + 5][4:0];
            expData         = patternMem[base + 6];
        end
        @(negedge clk);
        checkIssue($sformatf("pattern %0d", patternCount - 1), expWrite, expIndex, expData);
        instrValid = 1'b0;
    endtask

    // Valid on every cycle, no gaps between issues
    task automatic runRandom();
        instrWord_t ins;
        word_t      a;
        word_t      b;
        logic       expWrite;
        regIndex_t  expIndex;
        word_t      expData;
        for (int i = 0; i < randomCount; i++) begin
            ins = randomInstr();
            a   = randomWord();
            b   = randomWord();
            @(negedge clk);
            if (i > 0) begin
                checkIssue($sformatf("random %0d", i - 1), expWrite, expIndex, expData);
            end
            instrValid  = 1'b1;
            instruction = ins;
            gprA        = a;
            gprB        = b;
            expWrite    = expectWrite(ins);
            expIndex    = ins.fields.rd;
            expData     = expectData(ins, a, b);
        end
        @(negedge clk);
        checkIssue($sformatf("random %0d", randomCount - 1), expWrite, expIndex, expData);
        instrValid = 1'b0;
    endtask

    initial begin : mainSequence
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instruction = '0;
        gprA        = '0;
        gprB        = '0;
        $readmemh("tests/shiftPatterns.mem", patternMem);

        // Outputs stay cleared for the whole reset
        repeat (8) begin
            @(negedge clk);
            checkResetState("reset held");
        end
        rstN = 1'b1;
        @(negedge clk);
        checkResetState("after reset");

        runPatterns();
        runRandom();

        $display("Done: no errors");
        $finish;
    end

    // Bound on the whole run
    initial begin : watchdog
        #(watchdogLimit);
        stopOnError("Simulation timed out before all tests finished");
    end

endmodule : shiftUnitTb
